//--- Makefile
TOP = tb_mini_core
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -Mdir obj_dir -f verilog.f

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
	  echo "Simulation reported a failure"; exit 1; \
	fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- logic/core_pkg.sv
package core_pkg;

  //////////////////////////////////////////////////
  // Widths and reset values
  //////////////////////////////////////////////////

  // Data and address width
  localparam int XLEN       = 32;
  // Register index width
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // First fetch address and PC increment
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
  localparam logic [XLEN-1:0] PC_STEP  = 32'h0000_0004;

  //////////////////////////////////////////////////
  // Opcode and funct encodings
  //////////////////////////////////////////////////

  // Major opcodes, kept subset of RV32I
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // funct3 codes
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  // Word store
  localparam logic [2:0] F3_SW      = 3'b010;

  // funct7 for SUB, ADD uses all zeros
  localparam logic [6:0] F7_SUB = 7'b0100000;

  //////////////////////////////////////////////////
  // Instruction formats
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_type_t;

  // Store immediate is split around rs2/rs1
  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    logic [6:0]            opcode;
  } s_type_t;

  // Upper 20 bits of the immediate
  typedef struct packed {
    logic [19:0]           imm;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } u_type_t;

  // One word, four views picked by opcode
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    u_type_t u;
  } instr_t;

endpackage

//--- logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  logic   clk_i,
  input  logic   arst_n_i,
  instr_if.exec  instr_i,
  store_if.exec  store_o
);

  core_pkg::instr_t          instr;
  logic [6:0]                opcode;
  logic [core_pkg::XLEN-1:0] rdata_a;
  logic [core_pkg::XLEN-1:0] rdata_b;
  logic [core_pkg::XLEN-1:0] imm_i;
  logic [core_pkg::XLEN-1:0] imm_s;
  logic [core_pkg::XLEN-1:0] imm_u;
  logic [core_pkg::XLEN-1:0] alu_res;
  logic                      alu_en;
  logic                      is_sw;
  logic                      transfer;
  // Pending store
  logic                      st_valid_q;
  logic [core_pkg::XLEN-1:0] st_addr_q;
  logic [core_pkg::XLEN-1:0] st_data_q;

  assign instr  = instr_i.instr;
  assign opcode = instr.r.opcode;

  // Stall while a store waits for the bus side
  assign instr_i.instr_ready = !st_valid_q;
  assign transfer            = instr_i.instr_valid && instr_i.instr_ready;

  //////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////

  assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  assign imm_u = {instr.u.imm, 12'h000};

  // rs1/rs2/rd sit at the same bits in every format
  reg_file reg_file_i (
    .clk_i     ( clk_i           ),
    .arst_n_i  ( arst_n_i        ),
    .raddr_a_i ( instr.r.rs1     ),
    .raddr_b_i ( instr.r.rs2     ),
    .waddr_i   ( instr.r.rd      ),
    .we_i      ( transfer && alu_en ),
    .wdata_i   ( alu_res         ),
    .rdata_a_o ( rdata_a         ),
    .rdata_b_o ( rdata_b         )
  );

  //////////////////////////////////////////////////
  // Decode and ALU
  //////////////////////////////////////////////////

  always_comb begin
    alu_res = '0;
    alu_en  = 1'b0;
    is_sw   = 1'b0;
    case (opcode)
      core_pkg::OPC_OP: begin
        alu_en = 1'b1;
        case (instr.r.funct3)
          core_pkg::F3_ADD_SUB: begin
            alu_res = (instr.r.funct7 == core_pkg::F7_SUB) ?
                      rdata_a - rdata_b : rdata_a + rdata_b;
          end
          core_pkg::F3_XOR: alu_res = rdata_a ^ rdata_b;
          core_pkg::F3_OR:  alu_res = rdata_a | rdata_b;
          core_pkg::F3_AND: alu_res = rdata_a & rdata_b;
          // Shifts and compares not kept
          default:          alu_en  = 1'b0;
        endcase
      end
      core_pkg::OPC_OP_IMM: begin
        // ADDI only
        alu_en  = (instr.i.funct3 == core_pkg::F3_ADD_SUB);
        alu_res = rdata_a + imm_i;
      end
      core_pkg::OPC_LUI: begin
        alu_en  = 1'b1;
        alu_res = imm_u;
      end
      core_pkg::OPC_AUIPC: begin
        alu_en  = 1'b1;
        alu_res = instr_i.pc + imm_u;
      end
      core_pkg::OPC_STORE: begin
        is_sw = (instr.s.funct3 == core_pkg::F3_SW);
      end
      // Anything else retires as a no-op
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // Store request
  //////////////////////////////////////////////////

  assign store_o.st_valid = st_valid_q;
  assign store_o.st_addr  = st_addr_q;
  assign store_o.st_data  = st_data_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      st_valid_q <= 1'b0;
    end else if (transfer && is_sw) begin
      st_valid_q <= 1'b1;
    end else if (st_valid_q && store_o.st_ready) begin
      st_valid_q <= 1'b0;
    end
  end

  // Address and data, held until accepted
  always_ff @(posedge clk_i) begin
    if (transfer && is_sw) begin
      st_addr_q <= rdata_a + imm_s;
      st_data_q <= rdata_b;
    end
  end

endmodule

//--- logic/instr_fetch.sv
`timescale 1ns/1ps

module instr_fetch (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Instruction Wishbone master
  output logic                      iwb_cyc_o,
  output logic                      iwb_stb_o,
  output logic [core_pkg::XLEN-1:0] iwb_adr_o,
  input  logic [core_pkg::XLEN-1:0] iwb_dat_i,
  input  logic                      iwb_ack_i,
  // To execute
  instr_if.fetch                    instr_o
);

  logic [core_pkg::XLEN-1:0] pc_q;
  core_pkg::instr_t          instr_q;
  // Low in the bus cycle, high in the hand-off
  logic                      handoff_q;
  logic                      cyc_q;
  logic                      transfer;

  assign transfer = instr_o.instr_valid && instr_o.instr_ready;

  // cyc and stb always move together
  assign iwb_cyc_o = cyc_q;
  assign iwb_stb_o = cyc_q;
  assign iwb_adr_o = pc_q;

  assign instr_o.instr_valid = handoff_q;
  assign instr_o.instr       = instr_q;
  assign instr_o.pc          = pc_q;

  //////////////////////////////////////////////////
  // PC and fetch FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      handoff_q <= 1'b0;
      cyc_q     <= 1'b0;
      pc_q      <= core_pkg::RESET_PC;
    end else if (!handoff_q) begin
      if (cyc_q && iwb_ack_i) begin
        // Word returned, drop the bus and hand it over
        cyc_q     <= 1'b0;
        handoff_q <= 1'b1;
      end else begin
        // First fetch after reset, else hold the cycle open
        cyc_q <= 1'b1;
      end
    end else if (transfer) begin
      // Accepted, next sequential fetch
      handoff_q <= 1'b0;
      cyc_q     <= 1'b1;
      pc_q      <= pc_q + core_pkg::PC_STEP;
    end
  end

  // Capture on ack
  always_ff @(posedge clk_i) begin
    if (cyc_q && iwb_ack_i) begin
      instr_q <= iwb_dat_i;
    end
  end

endmodule

//--- logic/instr_if.sv
`timescale 1ns/1ps

// Fetch to execute hand-off, one instruction with its PC
interface instr_if;

  logic                        instr_valid;
  logic                        instr_ready;
  core_pkg::instr_t            instr;
  logic [core_pkg::XLEN-1:0]   pc;

  // Fetch side presents the word
  modport fetch (
    output instr_valid, instr, pc,
    input  instr_ready
  );

  // Execute side accepts it
  modport exec (
    input  instr_valid, instr, pc,
    output instr_ready
  );

endinterface

//--- logic/mini_core.sv
`timescale 1ns/1ps

module mini_core (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Instruction bus
  output logic                      iwb_cyc_o,
  output logic                      iwb_stb_o,
  output logic [core_pkg::XLEN-1:0] iwb_adr_o,
  input  logic [core_pkg::XLEN-1:0] iwb_dat_i,
  input  logic                      iwb_ack_i,
  // Data bus, write only
  output logic                      dwb_cyc_o,
  output logic                      dwb_stb_o,
  output logic [core_pkg::XLEN-1:0] dwb_adr_o,
  output logic [core_pkg::XLEN-1:0] dwb_dat_o,
  input  logic                      dwb_ack_i
);

  // Internal valid/ready links
  instr_if instr_link ();
  store_if store_link ();

  //////////////////////////////////////////////////
  // Fetch
  //////////////////////////////////////////////////

  instr_fetch instr_fetch_i (
    .clk_i     ( clk_i      ),
    .arst_n_i  ( arst_n_i   ),
    .iwb_cyc_o ( iwb_cyc_o  ),
    .iwb_stb_o ( iwb_stb_o  ),
    .iwb_adr_o ( iwb_adr_o  ),
    .iwb_dat_i ( iwb_dat_i  ),
    .iwb_ack_i ( iwb_ack_i  ),
    .instr_o   ( instr_link )
  );

  // Decode, ALU, register file
  exec_unit exec_unit_i (
    .clk_i    ( clk_i      ),
    .arst_n_i ( arst_n_i   ),
    .instr_i  ( instr_link ),
    .store_o  ( store_link )
  );

  //////////////////////////////////////////////////
  // Store
  //////////////////////////////////////////////////

  store_unit store_unit_i (
    .clk_i     ( clk_i      ),
    .arst_n_i  ( arst_n_i   ),
    .store_i   ( store_link ),
    .dwb_cyc_o ( dwb_cyc_o  ),
    .dwb_stb_o ( dwb_stb_o  ),
    .dwb_adr_o ( dwb_adr_o  ),
    .dwb_dat_o ( dwb_dat_o  ),
    .dwb_ack_i ( dwb_ack_i  )
  );

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic                            we_i,
  input  logic [core_pkg::XLEN-1:0]       wdata_i,
  output logic [core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [core_pkg::XLEN-1:0]       rdata_b_o
);

  // x1..x31 only, x0 has no storage
  logic [core_pkg::XLEN-1:0] regs_q [1:core_pkg::NUM_REGS-1];

  // Combinational reads, index 0 reads zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < core_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      // Writes to x0 dropped here
      regs_q[waddr_i] <= wdata_i;
    end
  end

endmodule

//--- logic/store_if.sv
`timescale 1ns/1ps

// Execute to store unit, one pending word write
interface store_if;

  logic                        st_valid;
  logic                        st_ready;
  logic [core_pkg::XLEN-1:0]   st_addr;
  logic [core_pkg::XLEN-1:0]   st_data;

  // Request side
  modport exec (
    output st_valid, st_addr, st_data,
    input  st_ready
  );

  // Bus side
  modport store (
    input  st_valid, st_addr, st_data,
    output st_ready
  );

endinterface

//--- logic/store_unit.sv
`timescale 1ns/1ps

module store_unit (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  store_if.store                    store_i,
  // Data Wishbone master, writes only
  output logic                      dwb_cyc_o,
  output logic                      dwb_stb_o,
  output logic [core_pkg::XLEN-1:0] dwb_adr_o,
  output logic [core_pkg::XLEN-1:0] dwb_dat_o,
  input  logic                      dwb_ack_i
);

  logic                      busy_q;
  logic [core_pkg::XLEN-1:0] adr_q;
  logic [core_pkg::XLEN-1:0] dat_q;
  logic                      accept;

  // Ready only when idle
  assign store_i.st_ready = !busy_q;
  assign accept           = store_i.st_valid && !busy_q;

  // Bus cycle spans the whole busy period
  assign dwb_cyc_o = busy_q;
  assign dwb_stb_o = busy_q;
  assign dwb_adr_o = adr_q;
  assign dwb_dat_o = dat_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
    end else if (busy_q && dwb_ack_i) begin
      // Write done, back to idle
      busy_q <= 1'b0;
    end
  end

  // Stable from stb through ack
  always_ff @(posedge clk_i) begin
    if (accept) begin
      adr_q <= store_i.st_addr;
      dat_q <= store_i.st_data;
    end
  end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

// 4 ns clock, reset low for the first 8 rising edges
module tb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    // Released on a rising edge like every other input
    arst_n_o <= 1'b1;
  end

endmodule

//--- testbench/tb_mini_core.sv
`timescale 1ns/1ps

module tb_mini_core;

  localparam int          N_PAIRS    = 64;
  // 128 instructions, 12 cycles each, 4 ns period
  localparam int          TIMEOUT_NS = 128 * 12 * 4;
  localparam logic [31:0] SEED       = 32'hd89fe786;
  // LW, outside the kept subset
  localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
  // ADDI x0, x0, 0
  localparam logic [31:0] NOP_WORD   = {12'h000, 5'd0, core_pkg::F3_ADD_SUB, 5'd0,
                                        core_pkg::OPC_OP_IMM};

  logic        clk;
  logic        arst_n;
  logic        iwb_cyc;
  logic        iwb_stb;
  logic [31:0] iwb_adr;
  logic [31:0] iwb_dat = '0;
  logic        iwb_ack = 1'b0;
  logic        dwb_cyc;
  logic        dwb_stb;
  logic [31:0] dwb_adr;
  logic [31:0] dwb_dat;
  logic        dwb_ack = 1'b0;

  // Program image, ALU op at word 2*i, its SW at 2*i+1
  logic [31:0] prog_mem [0:127];
  logic [31:0] exp_addr [0:N_PAIRS-1];
  logic [31:0] exp_data [0:N_PAIRS-1];
  // Store source was x0
  logic        exp_x0   [0:N_PAIRS-1];

  // Slave wait states
  logic [31:0] bus_lfsr;
  logic        i_busy;
  logic [1:0]  i_wait;
  logic        d_busy;
  logic [1:0]  d_wait;

  logic [31:0] exp_fetch_pc;
  logic [6:0]  st_idx;

  int fetch_errs = 0;
  int bus_errs   = 0;
  int store_errs = 0;

  tb_clock_gen clk_gen_i (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  mini_core dut_i (
    .clk_i     ( clk     ),
    .arst_n_i  ( arst_n  ),
    .iwb_cyc_o ( iwb_cyc ),
    .iwb_stb_o ( iwb_stb ),
    .iwb_adr_o ( iwb_adr ),
    .iwb_dat_i ( iwb_dat ),
    .iwb_ack_i ( iwb_ack ),
    .dwb_cyc_o ( dwb_cyc ),
    .dwb_stb_o ( dwb_stb ),
    .dwb_adr_o ( dwb_adr ),
    .dwb_dat_o ( dwb_dat ),
    .dwb_ack_i ( dwb_ack )
  );

  //////////////////////////////////////////////////
  // Random source
  //////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] val);
    val = '0;
    for (int b = 0; b < n; b++) begin
      state = lfsr_step(state);
      val   = {val[30:0], state[0]};
    end
  endtask

  // NOP past the end of the program
  function automatic logic [31:0] fetch_word(input logic [31:0] adr);
    if (adr[31:9] == '0) begin
      return prog_mem[adr[8:2]];
    end else begin
      return NOP_WORD;
    end
  endfunction

  task automatic print_counts();
    $display("Error counts: fetch %0d, bus %0d, store %0d", fetch_errs, bus_errs, store_errs);
  endtask

  //////////////////////////////////////////////////
  // Wishbone slave models
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [31:0] r;
    if (!arst_n) begin
      bus_lfsr = SEED;
      iwb_ack <= 1'b0;
      iwb_dat <= '0;
      i_busy  <= 1'b0;
      i_wait  <= '0;
      dwb_ack <= 1'b0;
      d_busy  <= 1'b0;
      d_wait  <= '0;
    end else begin
      // Instruction side, delay drawn at the start of each cycle
      if (iwb_ack) begin
        iwb_ack <= 1'b0;
        i_busy  <= 1'b0;
      end else if (iwb_stb) begin
        if (!i_busy) begin
          draw_bits(bus_lfsr, 2, r);
          i_wait <= r[1:0];
          i_busy <= 1'b1;
        end else if (i_wait == 2'd0) begin
          iwb_ack <= 1'b1;
          iwb_dat <= fetch_word(iwb_adr);
        end else begin
          i_wait <= i_wait - 2'd1;
        end
      end
      // Data side, writes only
      if (dwb_ack) begin
        dwb_ack <= 1'b0;
        d_busy  <= 1'b0;
      end else if (dwb_stb) begin
        if (!d_busy) begin
          draw_bits(bus_lfsr, 2, r);
          d_wait <= r[1:0];
          d_busy <= 1'b1;
        end else if (d_wait == 2'd0) begin
          dwb_ack <= 1'b1;
        end else begin
          d_wait <= d_wait - 2'd1;
        end
      end
    end
  end

  // Next fetch address and next expected store
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_fetch_pc <= core_pkg::RESET_PC;
      st_idx       <= '0;
    end else begin
      if (iwb_stb && iwb_ack) begin
        exp_fetch_pc <= exp_fetch_pc + core_pkg::PC_STEP;
      end
      if (dwb_stb && dwb_ack) begin
        st_idx <= st_idx + 7'd1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  reset_idle_chk: assert property (@(posedge clk)
    !arst_n |-> !(iwb_cyc || iwb_stb || dwb_cyc || dwb_stb ||
                  dut_i.instr_link.instr_valid || dut_i.store_link.st_valid))
    else begin
      $display("Bus or valid signal active during reset at %0t", $time);
      bus_errs = bus_errs + 1;
    end

  fetch_adr_chk: assert property (@(posedge clk) disable iff (!arst_n)
    iwb_stb |-> iwb_adr == exp_fetch_pc)
    else begin
      $display("ERROR %0t: fetch address %h, expected %h",
               $time, $sampled(iwb_adr), $sampled(exp_fetch_pc));
      fetch_errs = fetch_errs + 1;
    end

  stb_cyc_chk: assert property (@(posedge clk) disable iff (!arst_n)
    (!iwb_stb || iwb_cyc) && (!dwb_stb || dwb_cyc))
    else begin
      $display("Strobe raised without cycle at %0t", $time);
      bus_errs = bus_errs + 1;
    end

  // Held until ack, dropped right after it
  iwb_hold_chk: assert property (@(posedge clk) disable iff (!arst_n)
    (iwb_stb && !iwb_ack) |=> iwb_stb && $stable(iwb_adr))
    else begin
      $display("Instruction bus request changed before ack at %0t", $time);
      bus_errs = bus_errs + 1;
    end

  dwb_hold_chk: assert property (@(posedge clk) disable iff (!arst_n)
    (dwb_stb && !dwb_ack) |=> dwb_stb && $stable(dwb_adr) && $stable(dwb_dat))
    else begin
      $display("Data bus request changed before ack at %0t", $time);
      bus_errs = bus_errs + 1;
    end

  ack_drop_chk: assert property (@(posedge clk) disable iff (!arst_n)
    ((iwb_stb && iwb_ack) || (dwb_stb && dwb_ack)) |=>
      !((iwb_stb && $past(iwb_ack)) || (dwb_stb && $past(dwb_ack))))
    else begin
      $display("Strobe still high the cycle after ack at %0t", $time);
      bus_errs = bus_errs + 1;
    end

  st_extra_chk: assert property (@(posedge clk) disable iff (!arst_n)
    (dwb_stb && dwb_ack) |-> int'(st_idx) < N_PAIRS)
    else begin
      $display("More data writes than stores in the program at %0t", $time);
      store_errs = store_errs + 1;
    end

  st_data_chk: assert property (@(posedge clk) disable iff (!arst_n)
    (dwb_stb && dwb_ack) |-> dwb_dat == exp_data[st_idx[5:0]])
    else begin
      $display("ERROR %0t: store %0d data %h, expected %h", $time,
               $sampled(st_idx), $sampled(dwb_dat), exp_data[$sampled(st_idx[5:0])]);
      store_errs = store_errs + 1;
    end

  st_addr_chk: assert property (@(posedge clk) disable iff (!arst_n)
    (dwb_stb && dwb_ack) |-> dwb_adr == exp_addr[st_idx[5:0]])
    else begin
      $display("ERROR %0t: store %0d address %h, expected %h", $time,
               $sampled(st_idx), $sampled(dwb_adr), exp_addr[$sampled(st_idx[5:0])]);
      store_errs = store_errs + 1;
    end

  st_x0_chk: assert property (@(posedge clk) disable iff (!arst_n)
    (dwb_stb && dwb_ack && exp_x0[st_idx[5:0]]) |-> dwb_dat == '0)
    else begin
      $display("ERROR %0t: x0 stored as %h", $time, $sampled(dwb_dat));
      store_errs = store_errs + 1;
    end

  //////////////////////////////////////////////////
  // Program, reference model, end of run
  //////////////////////////////////////////////////

  initial begin
    logic [31:0]      prog_lfsr;
    logic [31:0]      mregs [0:31];
    logic [31:0]      r;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      res;
    logic [31:0]      pc;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [11:0]      imm12;
    logic [19:0]      imm20;
    logic [11:0]      simm;
    logic             wr;
    int               kind;
    core_pkg::instr_t w;
    core_pkg::instr_t s;
    prog_lfsr = SEED;
    for (int k = 0; k < 32; k++) begin
      mregs[k] = '0;
    end
    for (int i = 0; i < N_PAIRS; i++) begin
      draw_bits(prog_lfsr, 4, r);
      // Eight kept ops plus one load
      kind = r % 9;
      draw_bits(prog_lfsr, 5, r);
      rd = r[4:0];
      draw_bits(prog_lfsr, 5, r);
      rs1 = r[4:0];
      draw_bits(prog_lfsr, 5, r);
      rs2 = r[4:0];
      draw_bits(prog_lfsr, 12, r);
      imm12 = r[11:0];
      draw_bits(prog_lfsr, 20, r);
      imm20 = r[19:0];
      draw_bits(prog_lfsr, 12, r);
      simm = r[11:0];
      // Force some writes into x0
      if (i % 16 == 5) begin
        rd = '0;
      end
      pc  = 32'(8 * i);
      a   = mregs[rs1];
      b   = mregs[rs2];
      res = '0;
      wr  = 1'b1;
      // Register fields first, I and U immediates overwrite the upper bits
      w       = '0;
      w.r.rd  = rd;
      w.r.rs1 = rs1;
      w.r.rs2 = rs2;
      case (kind)
        0, 1: begin
          w.r.opcode = core_pkg::OPC_OP;
          w.r.funct3 = core_pkg::F3_ADD_SUB;
          w.r.funct7 = (kind == 1) ? core_pkg::F7_SUB : 7'b0;
          res        = (kind == 1) ? a - b : a + b;
        end
        2: begin
          w.r.opcode = core_pkg::OPC_OP;
          w.r.funct3 = core_pkg::F3_AND;
          res        = a & b;
        end
        3: begin
          w.r.opcode = core_pkg::OPC_OP;
          w.r.funct3 = core_pkg::F3_OR;
          res        = a | b;
        end
        4: begin
          w.r.opcode = core_pkg::OPC_OP;
          w.r.funct3 = core_pkg::F3_XOR;
          res        = a ^ b;
        end
        5: begin
          w.i.opcode = core_pkg::OPC_OP_IMM;
          w.i.funct3 = core_pkg::F3_ADD_SUB;
          w.i.imm    = imm12;
          res        = a + {{20{imm12[11]}}, imm12};
        end
        6, 7: begin
          w.u.opcode = (kind == 6) ? core_pkg::OPC_LUI : core_pkg::OPC_AUIPC;
          w.u.imm    = imm20;
          res        = (kind == 6) ? {imm20, 12'h000} : pc + {imm20, 12'h000};
        end
        default: begin
          // Would write rd on a full core, a no-op here
          w.i.opcode = OPC_LOAD;
          w.i.funct3 = 3'b010;
          w.i.imm    = imm12;
          wr         = 1'b0;
        end
      endcase
      if (wr && rd != '0) begin
        mregs[rd] = res;
      end
      prog_mem[7'(2 * i)] = w;
      // SW rd, simm(x0)
      s          = '0;
      s.s.opcode = core_pkg::OPC_STORE;
      s.s.funct3 = core_pkg::F3_SW;
      s.s.rs2    = rd;
      s.s.imm_hi = simm[11:5];
      s.s.imm_lo = simm[4:0];
      prog_mem[7'(2 * i + 1)] = s;
      exp_addr[6'(i)] = {{20{simm[11]}}, simm};
      exp_data[6'(i)] = mregs[rd];
      exp_x0[6'(i)]   = (rd == '0);
    end
    wait (arst_n === 1'b1);
    while (int'(st_idx) < N_PAIRS) begin
      @(posedge clk);
    end
    // Let any stray write show up
    repeat (16) @(posedge clk);
    print_counts();
    if (fetch_errs + bus_errs + store_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns with %0d of %0d stores seen", TIMEOUT_NS, st_idx, N_PAIRS);
    print_counts();
    $display("Test failed");
    $finish;
  end

endmodule

//--- verilog.f
logic/core_pkg.sv
logic/instr_if.sv
logic/store_if.sv
logic/instr_fetch.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/store_unit.sv
logic/mini_core.sv
testbench/tb_clock_gen.sv
testbench/tb_mini_core.sv
